//--- hdl/clkPkg.sv
// Shared types and codes for the run-control and sync section
// Every module runs on MBOX_CLK with CLK as async reset
package clkPkg;

  // Counter widths
  localparam int burstW = 8;
  localparam int phaseW = 2;
  // Microword time field width
  localparam int timeW = 2;

  // Control group function codes (00x)
  localparam logic [2:0] fnStop       = 3'd0;
  localparam logic [2:0] fnStart      = 3'd1;
  localparam logic [2:0] fnSingleStep = 3'd2;
  localparam logic [2:0] fnBurst      = 3'd5;

  // Load group function codes (04x)
  localparam logic [2:0] fnLdBurstLo = 3'd2;
  localparam logic [2:0] fnLdBurstHi = 3'd3;
  localparam logic [2:0] fnLdRate    = 3'd4;
  localparam logic [2:0] fnLdDis     = 3'd5;

  // Diagnostic function group, upper octal digit of the code
  typedef enum logic [1:0] {
    ctlGroup  = 2'b00,
    loadGroup = 2'b01,
    readGroup = 2'b10
  } funcGroup_t;

  // One diagnostic command from the console
  typedef struct packed {
    logic       strobe;
    funcGroup_t group;
    // Function select within the group
    logic [2:0] ds;
    // EBUS data bits, loads use the low nibble only
    logic [6:0] data;
  } diagCmd_t;

  // Section clock disables, 1 blocks that section
  typedef struct packed {
    logic crmDis;
    logic edpDis;
    logic ctlDis;
  } sectionDis_t;

  // Load nibble, read as a count/rate or as the disable bits
  typedef union packed {
    logic [3:0] nibble;
    struct packed {
      logic spare;
      logic crmDis;
      logic edpDis;
      logic ctlDis;
    } dis;
  } loadWord_u;

  // Mode registers of clkFunc as seen by the other modules
  typedef struct packed {
    logic              go;
    logic              burst;
    logic              stepPending;
    // Rate divider select, tick every rateSel+1 cycles
    logic [1:0]        rateSel;
    logic [burstW-1:0] burstCount;
    sectionDis_t       dis;
  } modeState_t;

  // Readback word toward the console
  typedef struct packed {
    logic       valid;
    logic [5:0] data;
  } diagRead_t;

endpackage

//--- hdl/clkFunc.sv
`timescale 1ns/10ps

// Diagnostic function decode, mode registers, burst counter
// and the free-running rate divider
module clkFunc (
  input  logic                MBOX_CLK,
  input  logic                CLK,
  input  clkPkg::diagCmd_t    diagCmd,
  input  logic                eboxClk,
  output clkPkg::modeState_t  mode,
  output logic                srcReq
);

  logic              ctlStb;
  logic              loadStb;
  clkPkg::loadWord_u loadWord;
  logic [1:0]        rateCnt;
  logic              rateTick;
  logic              burstLive;
  logic              runDemand;

  // Group decode of the command strobe
  assign ctlStb  = diagCmd.strobe && (diagCmd.group == clkPkg::ctlGroup);
  assign loadStb = diagCmd.strobe && (diagCmd.group == clkPkg::loadGroup);

  // Low EBUS nibble carries all load data
  assign loadWord = diagCmd.data[3:0];

  // Rate divider, free running
  // Wraps through 3 if rateSel drops below the current count
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      rateCnt <= '0;
    end else if (rateTick) begin
      rateCnt <= '0;
    end else begin
      rateCnt <= rateCnt + 2'd1;
    end
  end

  assign rateTick = (rateCnt == mode.rateSel);

  // Burst only demands clocks while count is left
  assign burstLive = mode.burst && (mode.burstCount != '0);
  assign runDemand = mode.go || burstLive || mode.stepPending;

  // No request in the EBOX clock cycle itself
  // Counter and step flag are not yet updated there
  assign srcReq = rateTick && runDemand && !eboxClk;

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      mode <= '0;
    end else begin
      // One step consumed per EBOX clock
      if (eboxClk) begin
        mode.stepPending <= 1'b0;
      end

      // Burst countdown
      if (mode.burst) begin
        if (mode.burstCount == '0) begin
          // Empty count, nothing to run
          mode.burst <= 1'b0;
        end else if (eboxClk) begin
          mode.burstCount <= mode.burstCount - 1'b1;
          if (mode.burstCount == clkPkg::burstW'(1)) begin
            mode.burst <= 1'b0;
          end
        end
      end

      // Control functions, unlisted codes ignored
      if (ctlStb) begin
        case (diagCmd.ds)
          clkPkg::fnStop: begin
            mode.go    <= 1'b0;
            mode.burst <= 1'b0;
          end
          clkPkg::fnStart:      mode.go          <= 1'b1;
          clkPkg::fnSingleStep: mode.stepPending <= 1'b1;
          clkPkg::fnBurst:      mode.burst       <= 1'b1;
          default: ;
        endcase
      end

      // Load functions, 046 and 047 ignored
      if (loadStb) begin
        case (diagCmd.ds)
          clkPkg::fnLdBurstLo:
            mode.burstCount[clkPkg::burstW/2-1:0] <= loadWord.nibble;
          clkPkg::fnLdBurstHi:
            mode.burstCount[clkPkg::burstW-1:clkPkg::burstW/2] <= loadWord.nibble;
          clkPkg::fnLdRate:
            mode.rateSel <= loadWord.nibble[1:0];
          clkPkg::fnLdDis: begin
            mode.dis.crmDis <= loadWord.dis.crmDis;
            mode.dis.edpDis <= loadWord.dis.edpDis;
            mode.dis.ctlDis <= loadWord.dis.ctlDis;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- hdl/clkSync.sv
`timescale 1ns/10ps

// MBOX phase counter and sync point detect
module clkSync (
  input  logic                      MBOX_CLK,
  input  logic                      CLK,
  input  logic [clkPkg::timeW-1:0]  crmTime,
  input  logic                      eboxClk,
  output logic                      syncReady
);

  logic [clkPkg::phaseW-1:0] phaseCnt;
  logic                      phaseMax;
  logic                      phaseHold;

  // Count saturates at all ones
  assign phaseMax = &phaseCnt;

  // Counter is being cleared this cycle
  assign phaseHold = eboxClk;

  // MBOX cycles since the last EBOX clock
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      phaseCnt <= '0;
    end else if (phaseHold) begin
      phaseCnt <= '0;
    end else if (!phaseMax) begin
      phaseCnt <= phaseCnt + 1'b1;
    end
  end

  // Sync point once the time field has elapsed
  // Compare is blocked while the count clears
  assign syncReady = (phaseCnt >= crmTime) && !phaseHold;

endmodule

//--- hdl/clkEboxGate.sv
`timescale 1ns/10ps

// Pending source request and EBOX clock generation
module clkEboxGate (
  input  logic                MBOX_CLK,
  input  logic                CLK,
  input  logic                srcReq,
  input  logic                syncReady,
  input  logic                mboxWait,
  input  logic                mboxResp,
  input  clkPkg::sectionDis_t dis,
  output logic                eboxClk,
  output logic                crmClk,
  output logic                edpClk,
  output logic                ctlClk,
  output logic                pending
);

  logic mboxOk;
  logic fire;

  // MBOX wait blocks the clock until the response shows up
  assign mboxOk = !mboxWait || mboxResp;

  // All conditions met, clock goes out next cycle
  assign fire = pending && syncReady && mboxOk;

  // One request held at most
  // Extra requests while pending merge into it
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      pending <= 1'b0;
    end else if (pending) begin
      pending <= !fire;
    end else begin
      pending <= srcReq;
    end
  end

  // EBOX clock strobe, one cycle wide
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      eboxClk <= 1'b0;
    end else begin
      eboxClk <= fire;
    end
  end

  // Section clocks follow eboxClk unless disabled
  assign crmClk = eboxClk && !dis.crmDis;
  assign edpClk = eboxClk && !dis.edpDis;
  assign ctlClk = eboxClk && !dis.ctlDis;

endmodule

//--- hdl/clkDiagRead.sv
`timescale 1ns/10ps

// Diagnostic readback, one cycle after the read strobe
module clkDiagRead (
  input  logic               MBOX_CLK,
  input  logic               CLK,
  input  clkPkg::diagCmd_t   diagCmd,
  input  clkPkg::modeState_t mode,
  input  logic               pending,
  input  logic               mboxWait,
  output clkPkg::diagRead_t  diagRead
);

  logic       readStb;
  logic [5:0] statusWord;
  logic       readValid;
  logic [5:0] readData;

  assign readStb = diagCmd.strobe && (diagCmd.group == clkPkg::readGroup);

  // Status selected by ds of the read command
  always_comb begin
    case (diagCmd.ds)
      3'd0: statusWord = {mode.go, mode.burst, mode.stepPending, pending, mode.rateSel};
      3'd1: statusWord = mode.burstCount[7:2];
      3'd2: statusWord = {mode.burstCount[1:0], mode.dis.crmDis, mode.dis.edpDis,
                          mode.dis.ctlDis, mboxWait};
      // Upper selects read as zero
      default: statusWord = '0;
    endcase
  end

  // Valid strobe
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      readValid <= 1'b0;
    end else begin
      readValid <= readStb;
    end
  end

  // Status captured with the strobe, mboxWait sampled here too
  always_ff @(posedge MBOX_CLK) begin
    if (readStb) begin
      readData <= statusWord;
    end
  end

  assign diagRead.valid = readValid;
  assign diagRead.data  = readData;

endmodule

//--- hdl/clkTop.sv
`timescale 1ns/10ps

// Run control and sync section, top level
module clkTop (
  input  logic                      MBOX_CLK,
  input  logic                      CLK,
  input  clkPkg::diagCmd_t          diagCmd,
  input  logic [clkPkg::timeW-1:0]  crmTime,
  input  logic                      mboxWait,
  input  logic                      mboxResp,
  output logic                      eboxClk,
  output logic                      crmClk,
  output logic                      edpClk,
  output logic                      ctlClk,
  output clkPkg::diagRead_t         diagRead
);

  clkPkg::modeState_t mode;
  logic               srcReq;
  logic               syncReady;
  logic               pending;

  // Command decode and mode registers
  clkFunc uFunc (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .diagCmd  (diagCmd),
    .eboxClk  (eboxClk),
    .mode     (mode),
    .srcReq   (srcReq)
  );

  // Phase count against the time field
  clkSync uSync (
    .MBOX_CLK  (MBOX_CLK),
    .CLK       (CLK),
    .crmTime   (crmTime),
    .eboxClk   (eboxClk),
    .syncReady (syncReady)
  );

  clkEboxGate uGate (
    .MBOX_CLK  (MBOX_CLK),
    .CLK       (CLK),
    .srcReq    (srcReq),
    .syncReady (syncReady),
    .mboxWait  (mboxWait),
    .mboxResp  (mboxResp),
    .dis       (mode.dis),
    .eboxClk   (eboxClk),
    .crmClk    (crmClk),
    .edpClk    (edpClk),
    .ctlClk    (ctlClk),
    .pending   (pending)
  );

  // Status readback
  clkDiagRead uDiagRead (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .diagCmd  (diagCmd),
    .mode     (mode),
    .pending  (pending),
    .mboxWait (mboxWait),
    .diagRead (diagRead)
  );

endmodule

//--- tb/clk_props.sv
`timescale 1ns/10ps

// Concurrent checks on the clock section outputs
module clkProps (
  input logic                     MBOX_CLK,
  input logic                     CLK,
  input logic                     eboxClk,
  input logic                     crmClk,
  input logic                     edpClk,
  input logic                     ctlClk,
  input logic [clkPkg::timeW-1:0] crmTime,
  input logic                     mboxWait,
  input logic                     mboxResp,
  input clkPkg::sectionDis_t      dis,
  input clkPkg::diagCmd_t         diagCmd,
  input clkPkg::diagRead_t        diagRead
);

  int         failCount = 0;
  logic [2:0] gapCnt;
  logic       readStb;

  assign readStb = diagCmd.strobe && (diagCmd.group == clkPkg::readGroup);

  // Cycles since the last EBOX clock, saturating
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      gapCnt <= 3'd7;
    end else if (eboxClk) begin
      gapCnt <= 3'd1;
    end else if (gapCnt != 3'd7) begin
      gapCnt <= gapCnt + 3'd1;
    end
  end

  // Never two adjacent cycles
  aNoAdjacent: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    eboxClk |=> !eboxClk)
    else begin
      $error("eboxClk high in adjacent cycles");
      failCount++;
    end

  // Sync point spacing
  aSpacing: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    eboxClk |-> gapCnt >= ({1'b0, $past(crmTime)} + 3'd1))
    else begin
      $error("eboxClk closer than crmTime+1 cycles");
      failCount++;
    end

  // Blocked while waiting without response
  aMboxWait: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    (mboxWait && !mboxResp) |=> !eboxClk)
    else begin
      $error("eboxClk during MBOX wait");
      failCount++;
    end

  aCrmGate: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    crmClk == (eboxClk && !dis.crmDis))
    else begin
      $error("crmClk gating wrong");
      failCount++;
    end

  aEdpGate: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    edpClk == (eboxClk && !dis.edpDis))
    else begin
      $error("edpClk gating wrong");
      failCount++;
    end

  aCtlGate: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    ctlClk == (eboxClk && !dis.ctlDis))
    else begin
      $error("ctlClk gating wrong");
      failCount++;
    end

  // Read valid exactly one cycle after the strobe
  aReadValid: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    readStb |=> diagRead.valid)
    else begin
      $error("diagRead.valid missing after read");
      failCount++;
    end

  aReadQuiet: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    !readStb |=> !diagRead.valid)
    else begin
      $error("diagRead.valid without read");
      failCount++;
    end

endmodule

bind clkTop clkProps uProps (
  .MBOX_CLK (MBOX_CLK),
  .CLK      (CLK),
  .eboxClk  (eboxClk),
  .crmClk   (crmClk),
  .edpClk   (edpClk),
  .ctlClk   (ctlClk),
  .crmTime  (crmTime),
  .mboxWait (mboxWait),
  .mboxResp (mboxResp),
  .dis      (mode.dis),
  .diagCmd  (diagCmd),
  .diagRead (diagRead)
);

//--- tb/clkTb.sv
`timescale 1ns/10ps

// Testbench for the run-control and sync section
module clkTb;

  logic                     MBOX_CLK;
  logic                     CLK;
  clkPkg::diagCmd_t         diagCmd;
  logic [clkPkg::timeW-1:0] crmTime;
  logic                     mboxWait;
  logic                     mboxResp;
  logic                     eboxClk;
  logic                     crmClk;
  logic                     edpClk;
  logic                     ctlClk;
  clkPkg::diagRead_t        diagRead;

  logic [31:0] rngState;
  logic        randomOn;
  int          pulseCount;
  int          burstLen;
  int          stopSnap;
  int          waitCnt;
  logic [5:0]  status;

  clkTop UUT (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .diagCmd  (diagCmd),
    .crmTime  (crmTime),
    .mboxWait (mboxWait),
    .mboxResp (mboxResp),
    .eboxClk  (eboxClk),
    .crmClk   (crmClk),
    .edpClk   (edpClk),
    .ctlClk   (ctlClk),
    .diagRead (diagRead)
  );

  // 20 ns clock
  always #10 MBOX_CLK = ~MBOX_CLK;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Old value of eboxClk at the edge, one count per strobe
  always @(posedge MBOX_CLK) begin
    if (!CLK && eboxClk) begin
      pulseCount = pulseCount + 1;
    end
  end

  // Random time field and MBOX wait pattern
  always @(negedge MBOX_CLK) begin
    if (randomOn) begin
      rngState = xorshift(rngState);
      crmTime  = rngState[1:0];
      mboxWait = (rngState[3:2] == 2'd0);
      mboxResp = (rngState[6:4] == 3'd0);
    end
  end

  // Any failed property ends the run here
  always @(negedge MBOX_CLK) begin
    if (UUT.uProps.failCount != 0) begin
      $display("a property check failed at %0t", $time);
      $display("Finished with errors");
      $fatal(1);
    end
  end

  task automatic checkValue(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic timedOut(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  // One-cycle command strobe
  task automatic issueCmd(input clkPkg::funcGroup_t group, input logic [2:0] ds,
                          input logic [6:0] data);
    @(negedge MBOX_CLK);
    diagCmd.strobe = 1'b1;
    diagCmd.group  = group;
    diagCmd.ds     = ds;
    diagCmd.data   = data;
    @(negedge MBOX_CLK);
    diagCmd.strobe = 1'b0;
  endtask

  task automatic readStatus(input logic [2:0] ds, output logic [5:0] data);
    int tries;
    issueCmd(clkPkg::readGroup, ds, 7'd0);
    tries = 0;
    while (!diagRead.valid) begin
      tries++;
      if (tries > 4) begin
        timedOut("diagRead.valid");
      end
      @(negedge MBOX_CLK);
    end
    data = diagRead.data;
  endtask

  // Let any pending request fire before state is read
  task automatic stopAndDrain();
    issueCmd(clkPkg::ctlGroup, clkPkg::fnStop, 7'd0);
    repeat (12) @(negedge MBOX_CLK);
  endtask

  task automatic waitPulses(input int target, input string what);
    waitCnt = 0;
    while (pulseCount < target) begin
      waitCnt++;
      if (waitCnt > 2000) begin
        timedOut(what);
      end
      @(negedge MBOX_CLK);
    end
  endtask

  initial begin
    MBOX_CLK   = 1'b0;
    CLK        = 1'b1;
    diagCmd    = '0;
    crmTime    = '0;
    mboxWait   = 1'b0;
    mboxResp   = 1'b0;
    rngState   = 32'd5826;
    randomOn   = 1'b0;
    pulseCount = 0;
    repeat (3) @(negedge MBOX_CLK);
    CLK = 1'b0;

    // Reset state, nothing moves before the first command
    repeat (6) begin
      @(negedge MBOX_CLK);
      checkValue("eboxClk", 0, eboxClk);
      checkValue("crmClk", 0, crmClk);
      checkValue("edpClk", 0, edpClk);
      checkValue("ctlClk", 0, ctlClk);
      checkValue("diagRead.valid", 0, diagRead.valid);
    end
    readStatus(3'd0, status);
    checkValue("status ds0", 0, status);

    // Burst of random length under random wait and time field
    rngState = xorshift(rngState);
    burstLen = int'(rngState % 40) + 1;
    issueCmd(clkPkg::loadGroup, clkPkg::fnLdBurstLo, 7'(burstLen & 15));
    issueCmd(clkPkg::loadGroup, clkPkg::fnLdBurstHi, 7'(burstLen >> 4));
    randomOn   = 1'b1;
    pulseCount = 0;
    issueCmd(clkPkg::ctlGroup, clkPkg::fnBurst, 7'd0);
    status  = 6'h10;
    waitCnt = 0;
    while (status[4]) begin
      waitCnt++;
      if (waitCnt > 500) begin
        timedOut("end of burst");
      end
      readStatus(3'd0, status);
    end
    randomOn = 1'b0;
    mboxWait = 1'b0;
    mboxResp = 1'b0;
    repeat (10) @(negedge MBOX_CLK);
    checkValue("burst pulses", burstLen, pulseCount);
    readStatus(3'd1, status);
    checkValue("status ds1", 0, status);
    readStatus(3'd2, status);
    checkValue("status ds2", 0, status);

    // Single step gives one pulse
    pulseCount = 0;
    issueCmd(clkPkg::ctlGroup, clkPkg::fnSingleStep, 7'd0);
    waitPulses(1, "single step pulse");
    repeat (20) @(negedge MBOX_CLK);
    checkValue("step pulses", 1, pulseCount);

    // Free run with random spacing, then STOP
    randomOn   = 1'b1;
    pulseCount = 0;
    issueCmd(clkPkg::ctlGroup, clkPkg::fnStart, 7'd0);
    waitPulses(20, "free run pulses");
    @(negedge MBOX_CLK);
    stopSnap = pulseCount;
    diagCmd.strobe = 1'b1;
    diagCmd.group  = clkPkg::ctlGroup;
    diagCmd.ds     = clkPkg::fnStop;
    diagCmd.data   = 7'd0;
    @(negedge MBOX_CLK);
    diagCmd.strobe = 1'b0;
    randomOn = 1'b0;
    mboxWait = 1'b0;
    mboxResp = 1'b0;
    repeat (20) @(negedge MBOX_CLK);
    if (pulseCount - stopSnap > 1) begin
      $display("more than one eboxClk pulse followed STOP at %0t", $time);
      $display("Finished with errors");
      $fatal(1);
    end

    // MBOX wait holds the clock until the response
    mboxWait   = 1'b1;
    pulseCount = 0;
    issueCmd(clkPkg::ctlGroup, clkPkg::fnStart, 7'd0);
    repeat (20) @(negedge MBOX_CLK);
    checkValue("pulses under wait", 0, pulseCount);
    mboxResp = 1'b1;
    @(negedge MBOX_CLK);
    mboxResp = 1'b0;
    waitPulses(1, "pulse after mboxResp");
    mboxWait = 1'b0;
    waitPulses(5, "resumed run");
    stopAndDrain();

    // Rate, disable and count loads read back
    issueCmd(clkPkg::loadGroup, clkPkg::fnLdRate, 7'd3);
    issueCmd(clkPkg::loadGroup, clkPkg::fnLdDis, 7'b0000101);
    issueCmd(clkPkg::loadGroup, clkPkg::fnLdBurstLo, 7'hA);
    issueCmd(clkPkg::loadGroup, clkPkg::fnLdBurstHi, 7'h5);
    readStatus(3'd0, status);
    checkValue("status ds0", 6'b000011, status);
    readStatus(3'd1, status);
    checkValue("status ds1", 6'h16, status);
    readStatus(3'd2, status);
    checkValue("status ds2", 6'b101010, status);
    readStatus(3'd5, status);
    checkValue("status ds5", 0, status);

    // Section clocks under a disable pattern
    pulseCount = 0;
    issueCmd(clkPkg::ctlGroup, clkPkg::fnStart, 7'd0);
    waitPulses(6, "gated run");
    stopAndDrain();

    if (UUT.uProps.failCount != 0) begin
      $display("a property check failed");
      $display("Finished with errors");
      $fatal(1);
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

//--- flist.f
hdl/clkPkg.sv
hdl/clkFunc.sv
hdl/clkSync.sv
hdl/clkEboxGate.sv
hdl/clkDiagRead.sv
hdl/clkTop.sv
tb/clk_props.sv
tb/clkTb.sv

//--- Makefile
# Verilator build and run for the clock section testbench

TOP := clkTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): flist.f hdl/*.sv tb/*.sv
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)
	verilator --lint-only hdl/clkPkg.sv hdl/clkFunc.sv hdl/clkSync.sv \
		hdl/clkEboxGate.sv hdl/clkDiagRead.sv hdl/clkTop.sv --top-module clkTop

clean:
	rm -rf obj_dir
